//--- verilog.f
logic/norm_pkg.sv
logic/csr_pkg.sv
logic/norm_cfg_if.sv
logic/lzc_128.sv
logic/lzc_256.sv
logic/norm_csr.sv
logic/norm_shifter.sv
logic/wide_norm_top.sv
tests/wide_norm_props.sv
tests/wide_norm_tb.sv

//--- Bender.yml
package:
  name: wide_norm

sources:
  - logic/norm_pkg.sv
  - logic/csr_pkg.sv
  - logic/norm_cfg_if.sv
  - logic/lzc_128.sv
  - logic/lzc_256.sv
  - logic/norm_csr.sv
  - logic/norm_shifter.sv
  - logic/wide_norm_top.sv
  - target: test
    files:
      - tests/wide_norm_props.sv
      - tests/wide_norm_tb.sv

//--- tests/wide_norm_tb.sv
`default_nettype none

module wide_norm_tb;
    import norm_pkg::*;
    import csr_pkg::*;

    // sweep, zeros, two random runs, corners, register writes
    localparam int N_ITEMS = 256 + 4 + 160 + 40 + 2 + 5;

    typedef struct {
        mant_t mant;
        exp_t  expo;
        logic  zero;
        logic  uflow;
        logic  clamp;
    } expect_t;

    logic clk;
    logic rst_n;
    logic cfg_we;
    csr_addr_t cfg_addr;
    csr_data_t cfg_wdata;
    csr_data_t cfg_rdata;
    logic in_valid;
    mant_t in_mant;
    exp_t in_exp;
    logic out_valid;
    mant_t out_mant;
    exp_t out_exp;
    logic out_zero;
    logic out_uflow;
    logic out_clamp;

    // register contents as the model sees them
    exp_t sh_offset = '0;
    exp_t sh_min = RST_MIN_EXP;
    exp_t sh_max = RST_MAX_EXP;
    logic sh_flush = 1'b0;
    logic [31:0] lfsr = 32'h4b2e;
    expect_t exp_q[$];
    expect_t head;
    int i;
    logic [7:0] pos;
    mant_t word;

    wide_norm_top i_dut (.*);

    always #2 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic mismatch(input string what);
        abort_run($sformatf("MISMATCH at %0t: %s", $time, what));
    endtask

    function automatic mant_t rand_bits(input int n);
        mant_t r;
        int b;
        r = '0;
        for (b = 0; b < n; b++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd0000001) : (lfsr >> 1);
            r[b] = lfsr[0];
        end
        return r;
    endfunction

    // expected result from the normalization rules
    function automatic expect_t model(input mant_t m, input exp_t e);
        expect_t r;
        int b;
        int lz;
        int wide;
        lz = 255;
        for (b = 0; b < MANT_W; b++) begin
            if (m[b]) lz = 255 - b;
        end
        wide = int'(e) + int'(sh_offset) - lz;
        r = '{mant: m << lz, expo: exp_t'(wide), zero: 1'b0, uflow: 1'b0, clamp: 1'b0};
        if (m == '0) begin
            r.zero = 1'b1;
            r.expo = sh_min;
        end else if (wide < int'(sh_min)) begin
            r.uflow = 1'b1;
            r.expo = sh_min;
            if (sh_flush) r.mant = '0;
        end else if (wide > int'(sh_max)) begin
            r.clamp = 1'b1;
            r.expo = sh_max;
        end
        return r;
    endfunction

    task automatic send(input mant_t m, input exp_t e);
        @(posedge clk);
        in_valid <= 1'b1;
        in_mant <= m;
        in_exp <= e;
        exp_q.push_back(model(m, e));
    endtask

    // stop feeding and let the pipeline empty
    task automatic drain();
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    task automatic write_reg(input csr_addr_t a, input csr_data_t d);
        @(posedge clk);
        cfg_we <= 1'b1;
        cfg_addr <= a;
        cfg_wdata <= d;
        @(posedge clk);
        cfg_we <= 1'b0;
        case (a)
            ADDR_OFFSET: sh_offset = d;
            ADDR_MIN_EXP: sh_min = d;
            ADDR_MAX_EXP: sh_max = d;
            default: sh_flush = d[CTRL_FLUSH_BIT];
        endcase
        @(negedge clk);
        assert (cfg_rdata == ((a == ADDR_CTRL) ? {15'b0, d[0]} : d))
            else mismatch($sformatf("readback of register %0d gave %h", a, cfg_rdata));
    endtask

    always @(negedge clk) begin
        if (i_dut.i_props.fail_count != 0) mismatch("a timing property of the DUT failed");
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) abort_run("out_valid with no item pending");
            head = exp_q.pop_front();
            assert (out_zero == head.zero) else mismatch("zero flag");
            assert (out_uflow == head.uflow) else mismatch("underflow flag");
            assert (out_clamp == head.clamp) else mismatch("clamp flag");
            assert (out_exp == head.expo)
                else mismatch($sformatf("exponent %0d, expected %0d", out_exp, head.expo));
            assert (head.mant == '0 || out_mant[MANT_W-1]) else mismatch("bit 255 not set");
            assert (out_mant == head.mant) else mismatch($sformatf("mantissa %h", out_mant));
        end
    end

    initial begin
        #(4 * (20 * N_ITEMS + 4));
        abort_run("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        in_valid = 1'b0;
        in_mant = '0;
        in_exp = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // single bit at every position back to back
        for (i = 0; i < MANT_W; i++) send(mant_t'(1) << i, exp_t'(rand_bits(10)));
        for (i = 0; i < 4; i++) send('0, exp_t'(rand_bits(16)));
        drain();
        write_reg(ADDR_OFFSET, 16'sd37);
        write_reg(ADDR_MIN_EXP, -16'sd300);
        write_reg(ADDR_MAX_EXP, 16'sd400);
        write_reg(ADDR_CTRL, 16'h0000);
        // masked words with the leading one at a random position
        for (i = 0; i < 200; i++) begin
            if (i == 160) begin
                drain();
                write_reg(ADDR_CTRL, 16'h0001);
            end
            pos = 8'(rand_bits(8));
            word = rand_bits(MANT_W);
            send((word & ((mant_t'(1) << pos) - 1)) | (mant_t'(1) << pos),
                 exp_t'(rand_bits(10)) - 16'sd512);
        end
        send(mant_t'(1) << 255, 16'sd1000);
        send(mant_t'(1), -16'sd1000);
        drain();
        repeat (3) @(posedge clk);
        if (i_dut.i_props.fail_count != 0) begin
            mismatch("a timing property of the DUT failed");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/wide_norm_props.sv
`default_nettype none

module wide_norm_props (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid,
    input logic out_zero,
    input logic out_uflow,
    input logic out_clamp
);

    // number of failed assertions so far
    int fail_count = 0;

    // fixed two-cycle latency in both directions
    a_latency: assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> ##2 out_valid)
        else begin
            fail_count++;
            $error("out_valid missing two cycles after in_valid");
        end
    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, 2))
        else begin
            fail_count++;
            $error("out_valid without a matching in_valid");
        end

    a_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high during reset");
        end

    a_zero_clamp: assert property (@(posedge clk) !(out_zero && out_clamp))
        else begin
            fail_count++;
            $error("zero and clamp flags together");
        end
    a_flag_valid: assert property (@(posedge clk)
        (out_zero || out_uflow || out_clamp) |-> out_valid)
        else begin
            fail_count++;
            $error("status flag without out_valid");
        end

endmodule

bind wide_norm_top wide_norm_props i_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .out_valid(out_valid),
    .out_zero (out_zero),
    .out_uflow(out_uflow),
    .out_clamp(out_clamp)
);

`default_nettype wire

//--- logic/wide_norm_top.sv
`default_nettype none

module wide_norm_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_we,
    input  csr_pkg::csr_addr_t  cfg_addr,
    input  csr_pkg::csr_data_t  cfg_wdata,
    output csr_pkg::csr_data_t  cfg_rdata,
    input  logic                in_valid,
    input  norm_pkg::mant_t     in_mant,
    input  norm_pkg::exp_t      in_exp,
    output logic                out_valid,
    output norm_pkg::mant_t     out_mant,
    output norm_pkg::exp_t      out_exp,
    output logic                out_zero,
    output logic                out_uflow,
    output logic                out_clamp
);
    import norm_pkg::*;

    // stage 1 magnitude and its leading one
    mant_t  enc_mant;
    lzpos_t lz_pos;
    logic   lz_any;

    norm_cfg_if cfg_bus ();

    norm_csr i_csr (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_we   (cfg_we),
        .cfg_addr (cfg_addr),
        .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata),
        .cfg      (cfg_bus.csr)
    );

    // combinational, same cycle as stage 1
    lzc_256 i_lzc (
        .data_in(enc_mant),
        .lzc    (lz_pos),
        .valid  (lz_any)
    );

    norm_shifter i_shifter (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_mant  (in_mant),
        .in_exp   (in_exp),
        .lz_pos   (lz_pos),
        .lz_any   (lz_any),
        .enc_mant (enc_mant),
        .cfg      (cfg_bus.shifter),
        .out_valid(out_valid),
        .out_mant (out_mant),
        .out_exp  (out_exp),
        .out_zero (out_zero),
        .out_uflow(out_uflow),
        .out_clamp(out_clamp)
    );

endmodule

`default_nettype wire

//--- logic/norm_shifter.sv
`default_nettype none

module norm_shifter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  norm_pkg::mant_t   in_mant,
    input  norm_pkg::exp_t    in_exp,
    input  norm_pkg::lzpos_t  lz_pos,
    input  logic              lz_any,
    output norm_pkg::mant_t   enc_mant,
    norm_cfg_if.shifter       cfg,
    output logic              out_valid,
    output norm_pkg::mant_t   out_mant,
    output norm_pkg::exp_t    out_exp,
    output logic              out_zero,
    output logic              out_uflow,
    output logic              out_clamp
);
    import norm_pkg::*;

    // stage 1
    logic      s1_valid;
    mant_t     s1_mant;
    exp_t      s1_exp;

    // stage 2 next values
    lzpos_t    lz;
    exp_wide_t exp_adj;
    mant_t     nx_mant;
    exp_t      nx_exp;
    logic      nx_uflow;
    logic      nx_clamp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_mant <= in_mant;
            s1_exp  <= in_exp;
        end
    end

    // encoder sees the registered magnitude
    assign enc_mant = s1_mant;

    always_comb begin
        // leading zeros are the complement of the one position
        lz       = ~lz_pos;
        exp_adj  = exp_wide_t'(s1_exp) + exp_wide_t'(cfg.exp_offset) - exp_wide_t'(lz);
        nx_mant  = s1_mant << lz;
        nx_exp   = exp_adj[EXP_W-1:0];
        nx_uflow = 1'b0;
        nx_clamp = 1'b0;
        if (!lz_any) begin
            nx_mant = '0;
            nx_exp  = cfg.min_exp;
        end else if (exp_adj < exp_wide_t'(cfg.min_exp)) begin
            nx_uflow = 1'b1;
            nx_exp   = cfg.min_exp;
            if (cfg.flush_en) begin
                nx_mant = '0;
            end
        end else if (exp_adj > exp_wide_t'(cfg.max_exp)) begin
            nx_clamp = 1'b1;
            nx_exp   = cfg.max_exp;
        end
    end

    // flags only ever high alongside out_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_zero  <= 1'b0;
            out_uflow <= 1'b0;
            out_clamp <= 1'b0;
        end else begin
            out_valid <= s1_valid;
            out_zero  <= s1_valid & ~lz_any;
            out_uflow <= s1_valid & nx_uflow;
            out_clamp <= s1_valid & nx_clamp;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            out_mant <= nx_mant;
            out_exp  <= nx_exp;
        end
    end

endmodule

`default_nettype wire

//--- logic/norm_csr.sv
`default_nettype none

module norm_csr (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_we,
    input  csr_pkg::csr_addr_t  cfg_addr,
    input  csr_pkg::csr_data_t  cfg_wdata,
    output csr_pkg::csr_data_t  cfg_rdata,
    norm_cfg_if.csr             cfg
);
    import csr_pkg::*;

    // write port, one register per address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.exp_offset <= RST_OFFSET;
            cfg.min_exp    <= RST_MIN_EXP;
            cfg.max_exp    <= RST_MAX_EXP;
            cfg.flush_en   <= RST_FLUSH_EN;
        end else if (cfg_we) begin
            case (cfg_addr)
                ADDR_OFFSET: begin
                    cfg.exp_offset <= cfg_wdata;
                end
                ADDR_MIN_EXP: begin
                    cfg.min_exp <= cfg_wdata;
                end
                ADDR_MAX_EXP: begin
                    cfg.max_exp <= cfg_wdata;
                end
                ADDR_CTRL: begin
                    cfg.flush_en <= cfg_wdata[CTRL_FLUSH_BIT];
                end
            endcase
        end
    end

    // readback mux
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            ADDR_OFFSET: begin
                cfg_rdata = cfg.exp_offset;
            end
            ADDR_MIN_EXP: begin
                cfg_rdata = cfg.min_exp;
            end
            ADDR_MAX_EXP: begin
                cfg_rdata = cfg.max_exp;
            end
            ADDR_CTRL: begin
                cfg_rdata[CTRL_FLUSH_BIT] = cfg.flush_en;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/lzc_256.sv
`default_nettype none

module lzc_256 (
    input  norm_pkg::mant_t  data_in,
    output norm_pkg::lzpos_t lzc,
    output logic             valid
);
    import norm_pkg::*;

    // per-half leading one positions
    logic [6:0] lower_half_count;
    logic [6:0] upper_half_count;

    // any bit set in each half
    logic       lower_half_valid;
    logic       upper_half_valid;

    // lower count, only when the upper half is empty
    logic [6:0] lower_pass;

    lzc_128 i_lzc_lo (
        .data_in(data_in[MANT_W/2-1:0]),
        .lzc    (lower_half_count),
        .valid  (lower_half_valid)
    );

    lzc_128 i_lzc_hi (
        .data_in(data_in[MANT_W-1:MANT_W/2]),
        .lzc    (upper_half_count),
        .valid  (upper_half_valid)
    );

    assign lower_pass = {7{~upper_half_valid}} & lower_half_count;

    assign valid = upper_half_valid | lower_half_valid;

    // msb says which half holds the leading one
    assign lzc = {upper_half_valid, upper_half_count | lower_pass};

endmodule

`default_nettype wire

//--- logic/lzc_128.sv
`default_nettype none

module lzc_128 (
    input  logic [127:0] data_in,
    output logic [  6:0] lzc,
    output logic         valid
);

    // all tree levels packed in one array
    // level l starts at 256 - (256 >> l) and holds 128 >> l nodes
    logic       node_v   [255];
    logic [6:0] node_idx [255];

    genvar lvl, n;

    // leaves are the raw bits with an empty index
    for (n = 0; n < 128; n++) begin : g_leaf
        assign node_v[n]   = data_in[n];
        assign node_idx[n] = '0;
    end

    for (lvl = 1; lvl < 8; lvl++) begin : g_level
        localparam int CUR = 256 - (256 >> lvl);
        localparam int PRV = 256 - (256 >> (lvl - 1));

        for (n = 0; n < (128 >> lvl); n++) begin : g_node
            logic hi_v;

            assign hi_v = node_v[PRV + 2*n + 1];
            assign node_v[CUR + n] = hi_v | node_v[PRV + 2*n];
            // upper child wins, its index is all zero when it is empty
            assign node_idx[CUR + n] = node_idx[PRV + 2*n + 1]
                                     | ({7{~hi_v}} & node_idx[PRV + 2*n])
                                     | (7'(hi_v) << (lvl - 1));
        end
    end

    // root node
    assign lzc   = node_idx[254];
    assign valid = node_v[254];

endmodule

`default_nettype wire

//--- logic/norm_cfg_if.sv
`default_nettype none

interface norm_cfg_if;
    import norm_pkg::*;

    // static levels, sampled by the shifter every cycle
    exp_t exp_offset;
    exp_t min_exp;
    exp_t max_exp;
    logic flush_en;

    modport csr (output exp_offset, output min_exp, output max_exp, output flush_en);

    modport shifter (input exp_offset, input min_exp, input max_exp, input flush_en);

endinterface

`default_nettype wire

//--- logic/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int CSR_DATA_W = 16;

    typedef logic [1:0] csr_addr_t;
    typedef logic [CSR_DATA_W-1:0] csr_data_t;

    // register map
    localparam csr_addr_t ADDR_OFFSET = 2'd0;
    localparam csr_addr_t ADDR_MIN_EXP = 2'd1;
    localparam csr_addr_t ADDR_MAX_EXP = 2'd2;
    localparam csr_addr_t ADDR_CTRL = 2'd3;

    // ctrl register fields
    localparam int CTRL_FLUSH_BIT = 0;

    // reset values, symmetric range around zero
    localparam logic signed [CSR_DATA_W-1:0] RST_OFFSET = '0;
    localparam logic signed [CSR_DATA_W-1:0] RST_MIN_EXP = -16'sd16383;
    localparam logic signed [CSR_DATA_W-1:0] RST_MAX_EXP = 16'sd16383;
    localparam logic RST_FLUSH_EN = 1'b0;

endpackage

`default_nettype wire

//--- logic/norm_pkg.sv
`default_nettype none

package norm_pkg;

    // magnitude path
    localparam int MANT_W = 256;
    localparam int LZPOS_W = 8;

    // exponent path
    localparam int EXP_W = 16;
    // two guard bits so offset and shift cannot wrap before the range checks
    localparam int EXP_WIDE_W = 18;

    typedef logic [MANT_W-1:0] mant_t;

    // bit index of the leading one
    typedef logic [LZPOS_W-1:0] lzpos_t;

    typedef logic signed [EXP_W-1:0] exp_t;

    typedef logic signed [EXP_WIDE_W-1:0] exp_wide_t;

endpackage

`default_nettype wire
